/* rtl/issue_pkg.sv */
package issue_pkg;

	// Datapath width and register file addressing
	localparam int XLEN = 32;
	localparam int REG_AW = 5;

	// Widths of the decoded control fields
	localparam int OPC_W = 7;
	localparam int ALU_FN_W = 4;
	localparam int FN_W = 3;
	localparam int MEM_OP_W = 4;

	// RV32I major opcode for loads (LB, LH, LW, LBU, LHU)
	localparam logic [OPC_W-1:0] OPC_LOAD = 7'b0000011;

	// Operand B source
	// Code 3 is not named and behaves like BSEL_REG
	typedef enum logic [1:0] {
		BSEL_REG = 2'b00,
		BSEL_IMM = 2'b01,
		BSEL_SHAMT = 2'b10
	} bsel_t;

	// Wrong-path bubbles after a taken branch or an exception
	localparam int SQUASH_CYCLES = 2;

	// Squash window counter
	// The cycle of the redirect itself is covered combinationally,
	// so the counter only holds the remaining cycles
	localparam int SQ_CW = $clog2(SQUASH_CYCLES + 1);
	localparam logic [SQ_CW-1:0] SQ_RELOAD = SQ_CW'(SQUASH_CYCLES - 1);

endpackage

/* rtl/hazard_if.sv */
`timescale 1ns/1ps

interface hazard_if;

	// Decode fields seen by the scoreboard
	logic [issue_pkg::REG_AW-1:0] rs1;
	logic [issue_pkg::REG_AW-1:0] rs2;
	logic [issue_pkg::REG_AW-1:0] rd;
	logic [issue_pkg::OPC_W-1:0] opcode;

	// Hazard levels back to the issue stage
	logic stall;
	logic squash;

	// Scoreboard side
	modport sb (
		input rs1,
		input rs2,
		input rd,
		input opcode,
		output stall,
		output squash
	);

	// Issue stage only needs the bubble requests
	modport stage (
		input stall,
		input squash
	);

endinterface

/* rtl/regfile.sv */
`timescale 1ns/1ps

module regfile (
	input logic clk,
	input logic nrst,
	input logic we,
	input logic [issue_pkg::REG_AW-1:0] waddr,
	input logic [issue_pkg::REG_AW-1:0] raddr_a,
	input logic [issue_pkg::REG_AW-1:0] raddr_b,
	input logic [issue_pkg::XLEN-1:0] wdata,
	output logic [issue_pkg::XLEN-1:0] rdata_a,
	output logic [issue_pkg::XLEN-1:0] rdata_b
);

	// x1..x31, x0 has no storage
	logic [issue_pkg::XLEN-1:0] regs [1:31];
	logic wr_en;

	assign wr_en = we && (waddr != '0);

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end
		else if (wr_en)
		begin
			regs[waddr] <= wdata;
		end
	end

	// Asynchronous reads with bypass of a same-cycle write
	assign rdata_a = (raddr_a == '0) ? '0 :
		(wr_en && (waddr == raddr_a)) ? wdata : regs[raddr_a];

	assign rdata_b = (raddr_b == '0) ? '0 :
		(wr_en && (waddr == raddr_b)) ? wdata : regs[raddr_b];

endmodule

/* rtl/scoreboard.sv */
`timescale 1ns/1ps

module scoreboard (
	input logic clk,
	input logic nrst,
	input logic btaken,
	input logic exception,
	hazard_if.sb hz
);

	logic redirect;
	logic squash;
	logic stall;
	logic [issue_pkg::SQ_CW-1:0] sq_cnt;

	// Last instruction that entered the issue register, if it was a load
	logic ld_valid;
	logic [issue_pkg::REG_AW-1:0] ld_rd;

	logic is_load;
	logic src_hit;

	// Squash window
	assign redirect = btaken | exception;
	assign squash = redirect | (sq_cnt != '0);

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			sq_cnt <= '0;
		end
		else if (redirect)
		begin
			// A new redirect restarts the window
			sq_cnt <= issue_pkg::SQ_RELOAD;
		end
		else if (sq_cnt != '0)
		begin
			sq_cnt <= sq_cnt - 1'b1;
		end
	end

	// Load-use detection
	// Loads to x0 never produce a hazard
	assign is_load = (hz.opcode == issue_pkg::OPC_LOAD) && (hz.rd != '0);
	assign src_hit = (ld_rd == hz.rs1) || (ld_rd == hz.rs2);

	// Squash has priority, stall is masked inside the window
	assign stall = ld_valid && src_hit && !squash;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			ld_valid <= 1'b0;
		end
		else
		begin
			// Only a load that really entered the issue register counts
			ld_valid <= is_load && !squash && !stall;
		end
	end

	always_ff @(posedge clk)
	begin
		if (is_load)
		begin
			ld_rd <= hz.rd;
		end
	end

	assign hz.squash = squash;
	assign hz.stall = stall;

endmodule

/* rtl/issue_stage.sv */
`timescale 1ns/1ps

module issue_stage (
	input logic clk,
	input logic nrst,

	// Decoded instruction
	input logic we3,
	input logic [issue_pkg::REG_AW-1:0] rd3,
	input logic [issue_pkg::REG_AW-1:0] rs1,
	input logic [issue_pkg::REG_AW-1:0] rs2,
	input logic [issue_pkg::REG_AW-1:0] shamt3,
	input logic [issue_pkg::ALU_FN_W-1:0] alu_fn3,
	input logic [issue_pkg::FN_W-1:0] fn3,
	input issue_pkg::bsel_t b_sel3,
	input logic [issue_pkg::XLEN-1:0] i_imm3,
	input logic [issue_pkg::XLEN-1:0] pc3,
	input logic [issue_pkg::MEM_OP_W-1:0] mem_op3,

	// Stall and squash from the scoreboard
	hazard_if.stage hz,

	// Register file read port
	output logic [issue_pkg::REG_AW-1:0] ra,
	output logic [issue_pkg::REG_AW-1:0] rb,
	input logic [issue_pkg::XLEN-1:0] rdata_a,
	input logic [issue_pkg::XLEN-1:0] rdata_b,

	// Toward execute
	output logic [issue_pkg::XLEN-1:0] op_a,
	output logic [issue_pkg::XLEN-1:0] op_b,
	output logic [issue_pkg::REG_AW-1:0] rd4,
	output logic [issue_pkg::ALU_FN_W-1:0] alu_fn4,
	output logic [issue_pkg::FN_W-1:0] fn4,
	output logic we4,
	output logic [issue_pkg::MEM_OP_W-1:0] mem_op4,
	output logic [issue_pkg::XLEN-1:0] pc4
);

	logic bubble;
	logic bubble_q;
	issue_pkg::bsel_t bsel_q;
	logic [issue_pkg::XLEN-1:0] imm_q;
	logic [issue_pkg::REG_AW-1:0] shamt_q;
	logic [issue_pkg::REG_AW-1:0] rs1_q;
	logic [issue_pkg::REG_AW-1:0] rs2_q;

	assign bubble = hz.stall | hz.squash;

	// Issue pipeline register
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			bubble_q <= 1'b1;
			we4 <= 1'b0;
			rd4 <= '0;
			alu_fn4 <= '0;
			fn4 <= '0;
			mem_op4 <= '0;
			bsel_q <= issue_pkg::BSEL_IMM;
			imm_q <= '0;
			rs1_q <= '0;
			rs2_q <= '0;
		end
		else if (bubble)
		begin
			// NOP: no write, immediate zero on B, sources at x0
			bubble_q <= 1'b1;
			we4 <= 1'b0;
			rd4 <= '0;
			alu_fn4 <= '0;
			fn4 <= '0;
			mem_op4 <= '0;
			bsel_q <= issue_pkg::BSEL_IMM;
			imm_q <= '0;
			rs1_q <= '0;
			rs2_q <= '0;
		end
		else
		begin
			bubble_q <= 1'b0;
			we4 <= we3;
			rd4 <= rd3;
			alu_fn4 <= alu_fn3;
			fn4 <= fn3;
			mem_op4 <= mem_op3;
			bsel_q <= b_sel3;
			imm_q <= i_imm3;
			rs1_q <= rs1;
			rs2_q <= rs2;
		end
	end

	// PC and shift amount follow decode every cycle
	always_ff @(posedge clk)
	begin
		pc4 <= pc3;
		shamt_q <= shamt3;
	end

	// Register file is read from the registered sources
	assign ra = rs1_q;
	assign rb = rs2_q;

	// Bubbles present zero on A
	assign op_a = bubble_q ? '0 : rdata_a;

	always_comb
	begin
		case (bsel_q)
			issue_pkg::BSEL_REG: op_b = rdata_b;
			issue_pkg::BSEL_IMM: op_b = imm_q;
			issue_pkg::BSEL_SHAMT:
				op_b = {{(issue_pkg::XLEN - issue_pkg::REG_AW){1'b0}}, shamt_q};
			// Unused code 3
			default: op_b = rdata_b;
		endcase
	end

endmodule

/* rtl/issue_top.sv */
`timescale 1ns/1ps

module issue_top (
	input logic clk,
	input logic nrst,

	// Write-back from commit
	input logic we6,
	input logic [issue_pkg::REG_AW-1:0] rdaddr6,
	input logic [issue_pkg::XLEN-1:0] wb6,

	// Decoded instruction
	input logic we3,
	input logic [issue_pkg::REG_AW-1:0] rd3,
	input logic [issue_pkg::REG_AW-1:0] rs1,
	input logic [issue_pkg::REG_AW-1:0] rs2,
	input logic [issue_pkg::OPC_W-1:0] opcode3,
	input logic [issue_pkg::ALU_FN_W-1:0] alu_fn3,
	input logic [issue_pkg::FN_W-1:0] fn3,
	input issue_pkg::bsel_t b_sel3,
	input logic [issue_pkg::XLEN-1:0] i_imm3,
	input logic [issue_pkg::REG_AW-1:0] shamt3,
	input logic [issue_pkg::XLEN-1:0] pc3,
	input logic [issue_pkg::MEM_OP_W-1:0] mem_op3,

	// Redirects from later stages
	input logic btaken,
	input logic exception,

	output logic [issue_pkg::XLEN-1:0] op_a,
	output logic [issue_pkg::XLEN-1:0] op_b,
	output logic [issue_pkg::REG_AW-1:0] rd4,
	output logic [issue_pkg::ALU_FN_W-1:0] alu_fn4,
	output logic [issue_pkg::FN_W-1:0] fn4,
	output logic we4,
	output logic [issue_pkg::MEM_OP_W-1:0] mem_op4,
	output logic [issue_pkg::XLEN-1:0] pc4,
	output logic stall
);

	logic [issue_pkg::REG_AW-1:0] ra;
	logic [issue_pkg::REG_AW-1:0] rb;
	logic [issue_pkg::XLEN-1:0] rdata_a;
	logic [issue_pkg::XLEN-1:0] rdata_b;

	hazard_if hz ();

	// Scoreboard looks at the instruction still in decode
	assign hz.rs1 = rs1;
	assign hz.rs2 = rs2;
	assign hz.rd = rd3;
	assign hz.opcode = opcode3;
	assign stall = hz.stall;

	regfile u_regfile (
		.clk(clk),
		.nrst(nrst),
		.we(we6),
		.waddr(rdaddr6),
		.raddr_a(ra),
		.raddr_b(rb),
		.wdata(wb6),
		.rdata_a(rdata_a),
		.rdata_b(rdata_b)
	);

	scoreboard u_scoreboard (
		.clk(clk),
		.nrst(nrst),
		.btaken(btaken),
		.exception(exception),
		.hz(hz.sb)
	);

	issue_stage u_issue_stage (
		.clk(clk),
		.nrst(nrst),
		.we3(we3),
		.rd3(rd3),
		.rs1(rs1),
		.rs2(rs2),
		.shamt3(shamt3),
		.alu_fn3(alu_fn3),
		.fn3(fn3),
		.b_sel3(b_sel3),
		.i_imm3(i_imm3),
		.pc3(pc3),
		.mem_op3(mem_op3),
		.hz(hz.stage),
		.ra(ra),
		.rb(rb),
		.rdata_a(rdata_a),
		.rdata_b(rdata_b),
		.op_a(op_a),
		.op_b(op_b),
		.rd4(rd4),
		.alu_fn4(alu_fn4),
		.fn4(fn4),
		.we4(we4),
		.mem_op4(mem_op4),
		.pc4(pc4)
	);

endmodule

/* tests/issue_properties.sv */
`timescale 1ns/1ps

module issue_properties (
	input logic clk,
	input logic nrst,
	input logic stall,
	input logic squash,
	input logic we4,
	input logic [issue_pkg::REG_AW-1:0] rd4,
	input logic [issue_pkg::REG_AW-1:0] ra,
	input logic [issue_pkg::XLEN-1:0] rdata_a
);

	// Hazard cycles load a NOP
	assert property (@(posedge clk) disable iff (!nrst)
		(stall || squash) |=> (!we4 && rd4 == '0))
		else $error("bubble not inserted after stall or squash");

	assert property (@(posedge clk) disable iff (!nrst) !(stall && squash))
		else $error("stall and squash high together");

	// Window covers the full squash length
	assert property (@(posedge clk) disable iff (!nrst)
		$rose(squash) |-> squash [* issue_pkg::SQUASH_CYCLES])
		else $error("squash window too short");

	assert property (@(posedge clk) disable iff (!nrst) (ra == '0) |-> (rdata_a == '0))
		else $error("x0 read returned nonzero");

endmodule

bind issue_stage issue_properties u_issue_properties (
	.clk(clk),
	.nrst(nrst),
	.stall(hz.stall),
	.squash(hz.squash),
	.we4(we4),
	.rd4(rd4),
	.ra(ra),
	.rdata_a(rdata_a)
);

/* tests/issue_tb.sv */
`timescale 1ns/1ps

module issue_tb;

	localparam int CLK_PERIOD = 4;
	localparam int TEST_CYCLES = 160;
	localparam int MARGIN_CYCLES = 60;
	localparam logic [6:0] OPC_ALU = 7'b0110011;

	logic clk = 1'b0;
	logic nrst;
	logic we6;
	logic [4:0] rdaddr6;
	logic [31:0] wb6;
	logic we3;
	logic [4:0] rd3, rs1, rs2, shamt3;
	logic [6:0] opcode3;
	logic [3:0] alu_fn3, mem_op3;
	logic [2:0] fn3;
	issue_pkg::bsel_t b_sel3;
	logic [31:0] i_imm3, pc3;
	logic btaken, exception;
	logic [31:0] op_a, op_b, pc4;
	logic [4:0] rd4;
	logic [3:0] alu_fn4, mem_op4;
	logic [2:0] fn4;
	logic we4, stall;

	// Expected register contents
	logic [31:0] model [0:31];
	logic [15:0] lfsr = 16'd41261;

	issue_top DUT (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	initial
	begin
		#((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
		$display("Watchdog expired before the tests finished");
		$display("SOME TESTS FAILED");
		$fatal(1, "timeout");
	end

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return v;
	endfunction

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1, "mismatch");
		end
	endtask

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic set_instr(input logic we, input logic [4:0] rd, input logic [4:0] s1,
		input logic [4:0] s2, input logic [6:0] opc, input issue_pkg::bsel_t bsel,
		input logic [31:0] imm);
		we3 = we;
		rd3 = rd;
		rs1 = s1;
		rs2 = s2;
		opcode3 = opc;
		b_sel3 = bsel;
		i_imm3 = imm;
		alu_fn3 = 4'(rand_bits(4));
		fn3 = 3'(rand_bits(3));
		mem_op3 = 4'(rand_bits(4));
		shamt3 = 5'(rand_bits(5));
		pc3 = rand_bits(32);
	endtask

	task automatic set_idle();
		set_instr(1'b0, 5'd0, 5'd0, 5'd0, 7'd0, issue_pkg::BSEL_IMM, 32'd0);
	endtask

	task automatic expect_bubble();
		check("we4 in bubble", 32'(we4), 0);
		check("rd4 in bubble", 32'(rd4), 0);
		check("op_a in bubble", op_a, 0);
	endtask

	task automatic test_reset();
		check("we4", 32'(we4), 0);
		check("rd4", 32'(rd4), 0);
		check("alu_fn4", 32'(alu_fn4), 0);
		check("fn4", 32'(fn4), 0);
		check("mem_op4", 32'(mem_op4), 0);
		check("op_a", op_a, 0);
		check("op_b", op_b, 0);
		check("stall", 32'(stall), 0);
	endtask

	task automatic write_reg(input logic [4:0] r, input logic [31:0] v);
		we6 = 1'b1;
		rdaddr6 = r;
		wb6 = v;
		step();
		if (r != 0)
			model[r] = v;
		we6 = 1'b0;
	endtask

	task automatic test_regfile();
		for (int i = 1; i < 32; i++)
			write_reg(i[4:0], rand_bits(32));
		for (int i = 1; i < 32; i++)
		begin
			set_instr(1'b1, 5'd1, i[4:0], 5'(32 - i), OPC_ALU, issue_pkg::BSEL_REG, 32'd0);
			step();
			set_idle();
			check("op_a read", op_a, model[i]);
			check("op_b read", op_b, model[32 - i]);
		end
		// Same-cycle write is bypassed to the read
		set_instr(1'b1, 5'd1, 5'd9, 5'd9, OPC_ALU, issue_pkg::BSEL_REG, 32'd0);
		step();
		set_idle();
		we6 = 1'b1;
		rdaddr6 = 5'd9;
		wb6 = rand_bits(32);
		#1;
		check("op_a bypass", op_a, wb6);
		check("op_b bypass", op_b, wb6);
		write_reg(5'd9, wb6);
		write_reg(5'd0, 32'hdeadbeef);
		set_instr(1'b1, 5'd1, 5'd0, 5'd0, OPC_ALU, issue_pkg::BSEL_REG, 32'd0);
		step();
		set_idle();
		check("op_a x0", op_a, 0);
		check("op_b x0", op_b, 0);
	endtask

	task automatic issue_and_check(input issue_pkg::bsel_t bsel, input logic [31:0] exp_b);
		logic [3:0] alu;
		logic [2:0] fn;
		logic [3:0] mem;
		logic [31:0] pc;
		set_instr(1'b1, 5'd14, 5'd3, 5'd4, OPC_ALU, bsel, i_imm3);
		alu = alu_fn3;
		fn = fn3;
		mem = mem_op3;
		pc = pc3;
		step();
		check("op_b select", op_b, (bsel == issue_pkg::BSEL_SHAMT) ? 32'(shamt3) : exp_b);
		check("rd4", 32'(rd4), 14);
		check("we4", 32'(we4), 1);
		check("alu_fn4", 32'(alu_fn4), 32'(alu));
		check("fn4", 32'(fn4), 32'(fn));
		check("mem_op4", 32'(mem_op4), 32'(mem));
		check("pc4", pc4, pc);
	endtask

	task automatic test_bsel();
		i_imm3 = rand_bits(32);
		issue_and_check(issue_pkg::BSEL_IMM, i_imm3);
		issue_and_check(issue_pkg::BSEL_SHAMT, 32'd0);
		issue_and_check(issue_pkg::bsel_t'(2'b11), model[4]);
		set_idle();
	endtask

	task automatic test_load_use();
		set_instr(1'b1, 5'd5, 5'd1, 5'd2, issue_pkg::OPC_LOAD, issue_pkg::BSEL_IMM, 32'd8);
		step();
		check("load rd4", 32'(rd4), 5);
		set_instr(1'b1, 5'd6, 5'd5, 5'd2, OPC_ALU, issue_pkg::BSEL_REG, 32'd0);
		#1;
		check("load-use stall", 32'(stall), 1);
		step();
		expect_bubble();
		check("stall after bubble", 32'(stall), 0);
		step();
		check("user rd4", 32'(rd4), 6);
		check("user we4", 32'(we4), 1);
		// A load to x0 and an unrelated user do not stall
		set_instr(1'b1, 5'd0, 5'd1, 5'd2, issue_pkg::OPC_LOAD, issue_pkg::BSEL_IMM, 32'd0);
		step();
		set_instr(1'b1, 5'd6, 5'd0, 5'd0, OPC_ALU, issue_pkg::BSEL_REG, 32'd0);
		#1;
		check("stall x0 load", 32'(stall), 0);
		step();
		set_instr(1'b1, 5'd6, 5'd1, 5'd2, issue_pkg::OPC_LOAD, issue_pkg::BSEL_IMM, 32'd0);
		step();
		set_instr(1'b1, 5'd8, 5'd7, 5'd3, OPC_ALU, issue_pkg::BSEL_REG, 32'd0);
		#1;
		check("stall independent", 32'(stall), 0);
		step();
		set_idle();
	endtask

	task automatic test_squash(input logic use_exc);
		set_instr(1'b1, 5'd5, 5'd1, 5'd2, issue_pkg::OPC_LOAD, issue_pkg::BSEL_IMM, 32'd0);
		step();
		// Redirect with a dependent load in decode
		set_instr(1'b1, 5'd5, 5'd5, 5'd5, issue_pkg::OPC_LOAD, issue_pkg::BSEL_IMM, 32'd0);
		btaken = !use_exc;
		exception = use_exc;
		#1;
		check("stall under squash", 32'(stall), 0);
		step();
		btaken = 1'b0;
		exception = 1'b0;
		expect_bubble();
		// Wrong-path load to x5 must leave no record behind
		set_instr(1'b1, 5'd5, 5'd5, 5'd3, issue_pkg::OPC_LOAD, issue_pkg::BSEL_IMM, 32'd0);
		#1;
		check("stall in window", 32'(stall), 0);
		step();
		expect_bubble();
		set_instr(1'b1, 5'd12, 5'd5, 5'd3, OPC_ALU, issue_pkg::BSEL_REG, 32'd0);
		#1;
		check("stall after window", 32'(stall), 0);
		step();
		check("resume rd4", 32'(rd4), 12);
		check("resume we4", 32'(we4), 1);
		set_idle();
	endtask

	initial
	begin
		nrst = 1'b0;
		we6 = 1'b0;
		rdaddr6 = '0;
		wb6 = '0;
		btaken = 1'b0;
		exception = 1'b0;
		set_idle();
		for (int i = 0; i < 32; i++)
			model[i] = '0;
		repeat (8) @(posedge clk);
		#1;
		nrst = 1'b1;
		test_reset();
		test_regfile();
		test_bsel();
		test_load_use();
		test_squash(1'b0);
		test_squash(1'b1);
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

/* filelist.f */
rtl/issue_pkg.sv
rtl/hazard_if.sv
rtl/regfile.sv
rtl/scoreboard.sv
rtl/issue_stage.sv
rtl/issue_top.sv
tests/issue_properties.sv
tests/issue_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -j 0
TOP ?= issue_tb
FILELIST ?= filelist.f
OBJ_DIR ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
